//--- Bender.yml
package:
  name: ntm_vector_multiplier

sources:
  - ntm_vector_multiplier_pkg.sv
  - ntm_lane_if.sv
  - ntm_scalar_multiplier.sv
  - ntm_vector_loader.sv
  - ntm_vector_collector.sv
  - ntm_vector_multiplier.sv
  - target: test
    files:
      - ntm_vector_multiplier_props.sv
      - ntm_vector_multiplier_tb.sv

//--- ntm_lane_if.sv
/*
 * Lane bus
 * Operands and start toward one scalar multiplier, result and done back
 */

`timescale 1ns/1ns

interface ntm_lane_if
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) ();

  // Single-cycle kick, operands must hold until done
  logic                 start;
  logic [DATA_SIZE-1:0] modulo;
  logic [DATA_SIZE-1:0] data_a;
  logic [DATA_SIZE-1:0] data_b;

  // Result, valid in the done cycle and held after
  logic [DATA_SIZE-1:0] data_out;
  logic                 done;

  // Loader side
  modport feed (
    output start, modulo, data_a, data_b
  );

  // Multiplier side
  modport lane (
    input  start, modulo, data_a, data_b,
    output data_out, done
  );

  // Collector side
  modport drain (
    input data_out, done
  );

endinterface

//--- ntm_scalar_multiplier.sv
/*
 * Scalar modular multiplier, one lane
 * data_out = a * b mod m by reduce, shift and add, data-dependent latency
 */

`timescale 1ns/1ns

module ntm_scalar_multiplier
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE
) (
  input logic      CLK,
  input logic      RST,
  ntm_lane_if.lane lane
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  lane_state_t state;

  // One guard bit so that sums and doublings never wrap
  logic [DATA_SIZE:0] m_ext;
  logic [DATA_SIZE:0] acc;
  logic [DATA_SIZE:0] u;
  logic [DATA_SIZE:0] v;

  // Next values for one shift-and-add step
  logic [DATA_SIZE:0] acc_sum;
  logic [DATA_SIZE:0] acc_next;
  logic [DATA_SIZE:0] v_dbl;
  logic [DATA_SIZE:0] v_next;

  ////////////////////////////////////////////////////////////////////////////
  // Step arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign m_ext = {1'b0, lane.modulo};

  // acc and v are both below m here, so one subtraction is enough
  assign acc_sum  = acc + v;
  assign acc_next = (acc_sum >= m_ext) ? acc_sum - m_ext : acc_sum;

  // v < m < 2^DATA_SIZE, top bit is clear before the shift
  assign v_dbl  = {v[DATA_SIZE-1:0], 1'b0};
  assign v_next = (v_dbl >= m_ext) ? v_dbl - m_ext : v_dbl;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state         <= lane_idle;
      lane.data_out <= '0;
    end else begin
      case (state)
        lane_idle: begin
          if (lane.start) begin
            state <= lane_reduce;
          end
        end
        lane_reduce: begin
          // Leave once b is fully reduced
          if (v < m_ext) begin
            state <= lane_step;
          end
        end
        lane_step: begin
          // Multiplier bits used up, publish the product
          if (u == '0) begin
            lane.data_out <= acc[DATA_SIZE-1:0];
            state         <= lane_done;
          end
        end
        lane_done: begin
          state <= lane_idle;
        end
        default: begin
          state <= lane_idle;
        end
      endcase
    end
  end

  // One-cycle done, data_out already loaded
  assign lane.done = (state == lane_done);

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      lane_idle: begin
        if (lane.start) begin
          acc <= '0;
          u   <= {1'b0, lane.data_a};
          v   <= {1'b0, lane.data_b};
        end
      end
      lane_reduce: begin
        // Repeated subtraction, one per cycle
        if (v >= m_ext) begin
          v <= v - m_ext;
        end
      end
      lane_step: begin
        if (u != '0) begin
          // Add current power-of-two multiple of b when the bit is set
          if (u[0]) begin
            acc <= acc_next;
          end
          v <= v_next;
          u <= u >> 1;
        end
      end
      default: begin
        // Hold
      end
    endcase
  end

endmodule

//--- ntm_vector_collector.sv
/*
 * Vector result collector
 * Captures every lane result, streams them in element order, pulses READY
 */

`timescale 1ns/1ns

module ntm_vector_collector
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE,
  parameter int SIZE_N    = DEFAULT_SIZE_N
) (
  input  logic                 CLK,
  input  logic                 RST,
  ntm_lane_if.drain            lanes [SIZE_N],
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 READY
);

  localparam int IDX_W = (SIZE_N > 1) ? $clog2(SIZE_N) : 1;

  collect_state_t       state;
  logic [IDX_W-1:0]     out_idx;
  logic [SIZE_N-1:0]    captured;
  logic [SIZE_N-1:0]    lane_done;
  logic                 last_out;
  logic [DATA_SIZE-1:0] lane_data [SIZE_N];
  logic [DATA_SIZE-1:0] result [SIZE_N];

  // Flatten the lane buses for indexed access
  for (genvar i = 0; i < SIZE_N; i++) begin : g_lane
    assign lane_done[i] = lanes[i].done;
    assign lane_data[i] = lanes[i].data_out;
  end

  assign last_out = (state == collect_stream) && (out_idx == IDX_W'(SIZE_N - 1));

  // Result registers, loaded on each lane's done
  always_ff @(posedge CLK) begin
    for (int k = 0; k < SIZE_N; k++) begin
      if (lane_done[k]) begin
        result[k] <= lane_data[k];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Capture flags and output FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= collect_wait;
      captured        <= '0;
      out_idx         <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
      READY           <= 1'b0;
    end else begin
      // Flags clear together with the READY pulse
      captured <= last_out ? '0 : (captured | lane_done);
      case (state)
        collect_wait: begin
          READY <= 1'b0;
          if (&captured) begin
            DATA_OUT_ENABLE <= 1'b1;
            DATA_OUT        <= result[0];
            out_idx         <= '0;
            state           <= collect_stream;
          end
        end
        collect_stream: begin
          if (last_out) begin
            DATA_OUT_ENABLE <= 1'b0;
            READY           <= 1'b1;
            state           <= collect_finish;
          end else begin
            DATA_OUT <= result[out_idx + 1'b1];
            out_idx  <= out_idx + 1'b1;
          end
        end
        collect_finish: begin
          // End of the READY pulse
          READY <= 1'b0;
          state <= collect_wait;
        end
        default: begin
          state <= collect_wait;
        end
      endcase
    end
  end

endmodule

//--- ntm_vector_loader.sv
/*
 * Vector operand loader
 * Latches the modulus, spreads operand pairs over the lanes, starts them all
 */

`timescale 1ns/1ns

module ntm_vector_loader
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE,
  parameter int SIZE_N    = DEFAULT_SIZE_N
) (
  input logic                 CLK,
  input logic                 RST,
  input logic                 START,
  input logic [DATA_SIZE-1:0] MODULO_IN,
  input logic                 DATA_IN_ENABLE,
  input logic [DATA_SIZE-1:0] DATA_A_IN,
  input logic [DATA_SIZE-1:0] DATA_B_IN,
  ntm_lane_if.feed            lanes [SIZE_N]
);

  // At least one index bit, also for a single lane
  localparam int IDX_W = (SIZE_N > 1) ? $clog2(SIZE_N) : 1;

  logic [IDX_W-1:0]     wr_idx;
  logic                 loading;
  logic                 wr_en;
  logic                 last_write;
  logic                 start_pulse;
  logic [DATA_SIZE-1:0] modulo_reg;
  logic [DATA_SIZE-1:0] opa [SIZE_N];
  logic [DATA_SIZE-1:0] opb [SIZE_N];

  // Enables only count while a vector is being loaded
  assign wr_en      = loading && DATA_IN_ENABLE;
  assign last_write = wr_en && (wr_idx == IDX_W'(SIZE_N - 1));

  // Index and common start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_idx      <= '0;
      loading     <= 1'b0;
      start_pulse <= 1'b0;
    end else begin
      start_pulse <= last_write;
      if (START) begin
        wr_idx  <= '0;
        loading <= 1'b1;
      end else if (last_write) begin
        wr_idx  <= '0;
        loading <= 1'b0;
      end else if (wr_en) begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  // Modulus shared by every lane
  always_ff @(posedge CLK) begin
    if (START) begin
      modulo_reg <= MODULO_IN;
    end
  end

  // Per-lane operand registers
  for (genvar i = 0; i < SIZE_N; i++) begin : g_lane
    always_ff @(posedge CLK) begin
      if (wr_en && (wr_idx == IDX_W'(i))) begin
        opa[i] <= DATA_A_IN;
        opb[i] <= DATA_B_IN;
      end
    end

    assign lanes[i].start  = start_pulse;
    assign lanes[i].modulo = modulo_reg;
    assign lanes[i].data_a = opa[i];
    assign lanes[i].data_b = opb[i];
  end

endmodule

//--- ntm_vector_multiplier.f
ntm_vector_multiplier_pkg.sv
ntm_lane_if.sv
ntm_scalar_multiplier.sv
ntm_vector_loader.sv
ntm_vector_collector.sv
ntm_vector_multiplier.sv
ntm_vector_multiplier_props.sv
ntm_vector_multiplier_tb.sv

//--- ntm_vector_multiplier.sv
/*
 * Vector modular multiplier, top level
 * DATA_OUT[i] = DATA_A[i] * DATA_B[i] mod MODULO over SIZE_N parallel lanes
 */

`timescale 1ns/1ns

module ntm_vector_multiplier
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int DATA_SIZE = DEFAULT_DATA_SIZE,
  parameter int SIZE_N    = DEFAULT_SIZE_N
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 START,
  input  logic [DATA_SIZE-1:0] MODULO_IN,
  input  logic                 DATA_IN_ENABLE,
  input  logic [DATA_SIZE-1:0] DATA_A_IN,
  input  logic [DATA_SIZE-1:0] DATA_B_IN,
  output logic                 DATA_OUT_ENABLE,
  output logic [DATA_SIZE-1:0] DATA_OUT,
  output logic                 READY
);

  // One bus per lane
  ntm_lane_if #(.DATA_SIZE(DATA_SIZE)) lane_bus [SIZE_N] ();

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  ntm_vector_loader #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_N    (SIZE_N)
  ) u_loader (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .MODULO_IN      (MODULO_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_A_IN      (DATA_A_IN),
    .DATA_B_IN      (DATA_B_IN),
    .lanes          (lane_bus)
  );

  // Lanes, all started together, finishing in any order
  for (genvar i = 0; i < SIZE_N; i++) begin : g_lane
    ntm_scalar_multiplier #(
      .DATA_SIZE (DATA_SIZE)
    ) u_mult (
      .CLK  (CLK),
      .RST  (RST),
      .lane (lane_bus[i])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output side
  ////////////////////////////////////////////////////////////////////////////

  ntm_vector_collector #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_N    (SIZE_N)
  ) u_collector (
    .CLK             (CLK),
    .RST             (RST),
    .lanes           (lane_bus),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .DATA_OUT        (DATA_OUT),
    .READY           (READY)
  );

endmodule

//--- ntm_vector_multiplier_pkg.sv
/*
 * Vector modular multiplier package
 * State encodings for the lane and collector FSMs, default sizes
 */

package ntm_vector_multiplier_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Default sizes
  ////////////////////////////////////////////////////////////////////////////

  // Element width in bits
  parameter int DEFAULT_DATA_SIZE = 16;

  // Elements per vector, one lane each
  parameter int DEFAULT_SIZE_N = 4;

  ////////////////////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////////////////////

  // Scalar multiplier lane
  typedef enum logic [1:0] {
    lane_idle   = 2'd0,
    lane_reduce = 2'd1,
    lane_step   = 2'd2,
    lane_done   = 2'd3
  } lane_state_t;

  // Result collector
  typedef enum logic [1:0] {
    collect_wait   = 2'd0,
    collect_stream = 2'd1,
    collect_finish = 2'd2
  } collect_state_t;

endpackage

//--- ntm_vector_multiplier_props.sv
/*
 * Protocol checker for the vector modular multiplier
 * Output strobes and lane done pulses, bound into the top level
 */

`timescale 1ns/1ns

module ntm_vector_multiplier_props
  import ntm_vector_multiplier_pkg::*;
#(
  parameter int SIZE_N = DEFAULT_SIZE_N
) (
  input logic CLK,
  input logic RST,
  input logic DATA_OUT_ENABLE,
  input logic READY
);

  // Failed assertions, read back by the testbench
  int fail_count = 0;

  // Quiet outputs while in reset
  a_reset_quiet: assert property (@(posedge CLK) RST |-> !READY && !DATA_OUT_ENABLE)
    else begin
      $error("READY or DATA_OUT_ENABLE high during reset");
      fail_count++;
    end

  // READY only right behind the burst, one cycle long
  a_ready_pulse: assert property (@(posedge CLK) disable iff (RST)
    READY |-> $past(DATA_OUT_ENABLE) ##1 !READY)
    else begin
      $error("READY outside the end of a burst or held longer than one cycle");
      fail_count++;
    end

  // Exactly SIZE_N output cycles, READY right behind them
  a_burst: assert property (@(posedge CLK) disable iff (RST)
    $rose(DATA_OUT_ENABLE) |-> DATA_OUT_ENABLE [*SIZE_N] ##1 (!DATA_OUT_ENABLE && READY))
    else begin
      $error("Output burst length or closing READY wrong");
      fail_count++;
    end

  // One done per lane start, a single cycle long
  for (genvar i = 0; i < SIZE_N; i++) begin : g_lane_done
    lane_state_t lane_state;
    logic        lane_start;
    logic        busy;

    assign lane_state = ntm_vector_multiplier.g_lane[i].u_mult.state;
    assign lane_start = ntm_vector_multiplier.lane_bus[i].start;

    // Open from the start pulse up to the done cycle
    always_ff @(posedge CLK or posedge RST) begin
      if (RST) begin
        busy <= 1'b0;
      end else if (lane_start) begin
        busy <= 1'b1;
      end else if (lane_state == lane_done) begin
        busy <= 1'b0;
      end
    end

    a_done_pulse: assert property (@(posedge CLK) disable iff (RST)
      lane_state == lane_done |-> busy)
      else begin
        $error("Lane %0d done without a start or held longer than one cycle", i);
        fail_count++;
      end
  end

endmodule

bind ntm_vector_multiplier ntm_vector_multiplier_props #(
  .SIZE_N (SIZE_N)
) u_props (
  .CLK             (CLK),
  .RST             (RST),
  .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
  .READY           (READY)
);

//--- ntm_vector_multiplier_tb.sv
/*
 * Testbench for the vector modular multiplier
 * Directed and LCG vectors, each element checked against a 64-bit model
 */

`timescale 1ns/1ns

module ntm_vector_multiplier_tb
  import ntm_vector_multiplier_pkg::*;
();

  localparam int DATA_SIZE = DEFAULT_DATA_SIZE;
  localparam int SIZE_N    = DEFAULT_SIZE_N;
  // Modulus 1 with a large b needs about 2^16 reduce cycles
  localparam int TIMEOUT   = 100000;

  logic                 CLK;
  logic                 RST;
  logic                 start;
  logic [DATA_SIZE-1:0] modulo_in;
  logic                 data_in_enable;
  logic [DATA_SIZE-1:0] data_a_in;
  logic [DATA_SIZE-1:0] data_b_in;
  logic                 data_out_enable;
  logic [DATA_SIZE-1:0] data_out;
  logic                 ready;

  // Vector under test
  logic [DATA_SIZE-1:0] modulus;
  logic [DATA_SIZE-1:0] vec_a [SIZE_N];
  logic [DATA_SIZE-1:0] vec_b [SIZE_N];
  logic [31:0]          lcg_state;
  int                   errors;
  int                   tests;
  int                   failed;
  int                   prop_fails;

  ntm_vector_multiplier #(
    .DATA_SIZE (DATA_SIZE),
    .SIZE_N    (SIZE_N)
  ) u_dut (
    .CLK             (CLK),
    .RST             (RST),
    .START           (start),
    .MODULO_IN       (modulo_in),
    .DATA_IN_ENABLE  (data_in_enable),
    .DATA_A_IN       (data_a_in),
    .DATA_B_IN       (data_b_in),
    .DATA_OUT_ENABLE (data_out_enable),
    .DATA_OUT        (data_out),
    .READY           (ready)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Reference product, wide enough that nothing wraps
  function automatic logic [DATA_SIZE-1:0] mod_product(input logic [DATA_SIZE-1:0] a,
                                                       input logic [DATA_SIZE-1:0] b,
                                                       input logic [DATA_SIZE-1:0] m);
    longint unsigned prod;
    prod = 64'(a) * 64'(b);
    return DATA_SIZE'(prod % 64'(m));
  endfunction

  // Next drive point, 2 ns after the rising edge
  task automatic tick();
    @(posedge CLK);
    #2;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // One operation: START, SIZE_N pairs, checked output burst
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_vector(input string name, input bit gaps);
    int                   wait_cycles;
    int                   errs_before;
    logic [DATA_SIZE-1:0] expected;
    errs_before = errors;
    start     = 1'b1;
    modulo_in = modulus;
    tick();
    start = 1'b0;
    for (int i = 0; i < SIZE_N; i++) begin
      data_in_enable = 1'b1;
      data_a_in      = vec_a[i];
      data_b_in      = vec_b[i];
      tick();
      data_in_enable = 1'b0;
      // Random idle cycles between strobes
      if (gaps && i < SIZE_N - 1) begin
        repeat (lcg_next() % 4) tick();
      end
    end
    wait_cycles = 0;
    while (!data_out_enable && wait_cycles < TIMEOUT) begin
      tick();
      wait_cycles++;
    end
    if (!data_out_enable) begin
      $display("Timeout: no DATA_OUT_ENABLE within %0d cycles in %s", TIMEOUT, name);
      errors++;
    end else begin
      for (int i = 0; i < SIZE_N; i++) begin
        expected = mod_product(vec_a[i], vec_b[i], modulus);
        assert (data_out_enable) else begin
          $display("DATA_OUT_ENABLE dropped before element %0d in %s", i, name);
          errors++;
        end
        assert (data_out == expected) else begin
          $display("Mismatch at %0t ns: DATA_OUT element %0d is %0d, expected %0d",
                   $time, i, data_out, expected);
          errors++;
        end
        tick();
      end
      // Burst length and the READY that closes it
      assert (!data_out_enable) else begin
        $display("DATA_OUT_ENABLE stayed high past %0d cycles in %s", SIZE_N, name);
        errors++;
      end
      assert (ready) else begin
        $display("READY missing after the output burst in %s", name);
        errors++;
      end
    end
    tests++;
    if (errors == errs_before) begin
      $display("%s: ok", name);
    end else begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence, every START right after the previous READY
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lcg_state      = 32'he9b6;
    errors         = 0;
    tests          = 0;
    failed         = 0;
    RST            = 1'b1;
    start          = 1'b0;
    modulo_in      = '0;
    data_in_enable = 1'b0;
    data_a_in      = '0;
    data_b_in      = '0;
    repeat (4) @(posedge CLK);
    #2;
    RST = 1'b0;
    tick();

    modulus = 16'd97;
    vec_a   = '{16'd3, 16'd10, 16'd50, 16'd96};
    vec_b   = '{16'd5, 16'd20, 16'd60, 16'd96};
    run_vector("small operands below the modulus", 1'b0);

    // b at and far above m
    modulus = 16'd13;
    vec_a   = '{16'd7, 16'd2, 16'd12, 16'd1};
    vec_b   = '{16'd13, 16'd65535, 16'd1000, 16'd14};
    run_vector("b reduced before multiply", 1'b0);

    // Zeros, a of 1, then modulus 1
    modulus = 16'd101;
    vec_a   = '{16'd0, 16'd5, 16'd1, 16'd1};
    vec_b   = '{16'd9, 16'd0, 16'd100, 16'd250};
    run_vector("zero operands and a of one", 1'b0);
    modulus = 16'd1;
    vec_a   = '{16'd123, 16'd0, 16'd65535, 16'd1};
    vec_b   = '{16'd45, 16'd7, 16'd1, 16'd3};
    run_vector("modulus of one", 1'b0);

    // LCG vectors, odd ones with input gaps
    for (int k = 0; k < 8; k++) begin
      modulus = DATA_SIZE'(lcg_next() >> 12);
      if (modulus == '0) begin
        modulus = '1;
      end
      for (int i = 0; i < SIZE_N; i++) begin
        vec_a[i] = DATA_SIZE'(lcg_next() >> 12);
        vec_b[i] = DATA_SIZE'(lcg_next() >> 12);
      end
      run_vector($sformatf("random vector %0d", k), k % 2 == 1);
    end

    tick();
    // Failures of the bound checker count as well
    prop_fails = u_dut.u_props.fail_count;
    $display("Summary: %0d tests, %0d failed, %0d check errors, %0d property failures",
             tests, failed, errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
